/* Bender.yml */
package:
  name: spi_bridge

sources:
  # Synthesisable design, package first
  - include_dirs:
      - hdl
    files:
      - hdl/spi_bridge_pkg.sv
      - hdl/async_fifo.sv
      - hdl/spi_target.sv
      - hdl/bus_byte_mem.sv
      - hdl/spi_bridge_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/tb_spi_bridge.sv

/* filelist.f */
+incdir+hdl
+incdir+test
hdl/spi_bridge_pkg.sv
hdl/async_fifo.sv
hdl/spi_target.sv
hdl/bus_byte_mem.sv
hdl/spi_bridge_top.sv
test/tb_spi_bridge.sv

/* hdl/async_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

// Dual-clock byte FIFO
// Gray pointers cross into the other domain through two flops
module async_fifo #(
   parameter int ADDR_W = 4
) (
   // Write side
   input  logic       wr_clk_i,
   input  logic       wr_en_i,
   input  logic [7:0] wr_data_i,
   output logic       wfull_o,
   // Read side, first word falls through
   input  logic       rd_clk_i,
   input  logic       rd_en_i,
   output logic [7:0] rd_data_o,
   output logic       rempty_o,
   // Clears both pointer sets
   input  logic       rst_i
);

   localparam int DEPTH = 2 ** ADDR_W;

   logic [7:0]      mem [DEPTH];

   // One extra pointer bit tells full from empty
   logic [ADDR_W:0] wbin;
   logic [ADDR_W:0] wgray;
   logic [ADDR_W:0] wbin_next;
   logic [ADDR_W:0] rbin;
   logic [ADDR_W:0] rgray;
   logic [ADDR_W:0] rbin_next;

   // Synchronised copies of the opposite Gray pointer
   logic [ADDR_W:0] rgray_w1;
   logic [ADDR_W:0] rgray_w2;
   logic [ADDR_W:0] wgray_r1;
   logic [ADDR_W:0] wgray_r2;

   logic            wr_ok;
   logic            rd_ok;

   function automatic logic [ADDR_W:0] bin2gray(input logic [ADDR_W:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   //-------------------------------------------------------------------
   // Write domain
   //-------------------------------------------------------------------
   assign wr_ok     = wr_en_i && !wfull_o;
   assign wbin_next = wbin + 1'b1;

   always_ff @(posedge wr_clk_i or posedge rst_i) begin
      if (rst_i) begin
         wbin     <= '0;
         wgray    <= '0;
         rgray_w1 <= '0;
         rgray_w2 <= '0;
      end else begin
         rgray_w1 <= rgray;
         rgray_w2 <= rgray_w1;
         if (wr_ok) begin
            wbin  <= wbin_next;
            wgray <= bin2gray(wbin_next);
         end
      end
   end

   // Storage
   always_ff @(posedge wr_clk_i) begin
      if (wr_ok) begin
         mem[wbin[ADDR_W-1:0]] <= wr_data_i;
      end
   end

   // Full when the two top Gray bits differ and the rest match
   assign wfull_o = (wgray == {~rgray_w2[ADDR_W:ADDR_W-1], rgray_w2[ADDR_W-2:0]});

   //-------------------------------------------------------------------
   // Read domain
   //-------------------------------------------------------------------
   assign rd_ok     = rd_en_i && !rempty_o;
   assign rbin_next = rbin + 1'b1;

   always_ff @(posedge rd_clk_i or posedge rst_i) begin
      if (rst_i) begin
         rbin     <= '0;
         rgray    <= '0;
         wgray_r1 <= '0;
         wgray_r2 <= '0;
      end else begin
         wgray_r1 <= wgray;
         wgray_r2 <= wgray_r1;
         if (rd_ok) begin
            rbin  <= rbin_next;
            rgray <= bin2gray(rbin_next);
         end
      end
   end

   // Empty when both pointers agree
   assign rempty_o  = (rgray == wgray_r2);
   // Head of queue shown without a read strobe
   assign rd_data_o = mem[rbin[ADDR_W-1:0]];

endmodule

`default_nettype wire

/* hdl/bus_byte_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_consts.svh"

// Byte memory on the bus slave side
// Reads and writes walk their own pointers, both restart every frame
module bus_byte_mem (
   input  logic                     clk_i,
   input  logic                     SSEL,
   input  spi_bridge_pkg::bus_req_t bus_req_i,
   output spi_bridge_pkg::bus_rsp_t bus_rsp_o
);

   localparam int DEPTH = 2 ** `MEM_ADDR_W;

   logic [7:0]             mem [DEPTH];
   logic [`MEM_ADDR_W-1:0] rd_ptr;
   logic [`MEM_ADDR_W-1:0] wr_ptr;
   logic                   cyc_q;
   logic                   ack_q;
   logic [7:0]             rdat_q;
   logic                   take;
   logic                   frame_end;

   // New request, ignoring the cycle that already carries its ack
   assign take      = bus_req_i.cyc && bus_req_i.stb && !ack_q;
   // Falling edge of cyc
   assign frame_end = cyc_q && !bus_req_i.cyc;

   //--------------------------------------------------------------------
   // Control
   //--------------------------------------------------------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         cyc_q  <= 1'b0;
         ack_q  <= 1'b0;
         rd_ptr <= '0;
         wr_ptr <= '0;
      end else begin
         cyc_q <= bus_req_i.cyc;
         // Never stalls, ack always one cycle after the strobe
         ack_q <= take;
         if (frame_end) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
         end else if (take) begin
            // Pointers wrap at the memory size
            if (bus_req_i.we) begin
               wr_ptr <= wr_ptr + 1'b1;
            end else begin
               rd_ptr <= rd_ptr + 1'b1;
            end
         end
      end
   end

   //--------------------------------------------------------------------
   // Storage and read data
   //--------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (take && bus_req_i.we) begin
         mem[wr_ptr] <= bus_req_i.dat;
      end
      if (take && !bus_req_i.we) begin
         rdat_q <= mem[rd_ptr];
      end
   end

   assign bus_rsp_o = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

/* hdl/spi_bridge_consts.svh */
`ifndef SPI_BRIDGE_CONSTS_SVH
`define SPI_BRIDGE_CONSTS_SVH

//----------------------------------------------------------------------
// SPI framing
//----------------------------------------------------------------------

// Fixed byte shifted out on MISO at the start of every frame
`define SPI_HEADER_BYTE 8'hA7

//----------------------------------------------------------------------
// Storage sizes
//----------------------------------------------------------------------

// Log2 of the async FIFO depth, same for TX and RX
`define FIFO_ADDR_W 4

// Byte memory address width, 16 locations
`define MEM_ADDR_W 4

`endif

/* hdl/spi_bridge_pkg.sv */
`default_nettype none

package spi_bridge_pkg;

   //-------------------------------------------------------------------
   // Bus between the SPI target and the byte memory
   //-------------------------------------------------------------------

   // Master to slave
   typedef struct packed {
      // Frame, high for the whole time the target is selected
      logic       cyc;
      // Request strobe, held until ack
      logic       stb;
      // High for a write, low for a read
      logic       we;
      // Write data
      logic [7:0] dat;
   } bus_req_t;

   // Slave to master
   typedef struct packed {
      // One-cycle acknowledge
      logic       ack;
      // Read data, valid together with ack
      logic [7:0] dat;
   } bus_rsp_t;

   //-------------------------------------------------------------------
   // Diagnostics
   //-------------------------------------------------------------------

   // Sticky flags from the SPI clock domain
   typedef struct packed {
      // Received byte found the RX FIFO full
      logic overflow;
      // Byte boundary found the TX FIFO empty
      logic underrun;
   } spi_status_t;

endpackage

`default_nettype wire

/* hdl/spi_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

// SPI target joined to the byte memory
module spi_bridge_top (
   input  logic clk_i,
   input  logic SSEL,
   // SPI pins
   input  logic sck_i,
   input  logic mosi_i,
   output logic miso_o,
   // Sticky flags
   output logic overflow_o,
   output logic underrun_o
);

   spi_bridge_pkg::bus_req_t    bus_req;
   spi_bridge_pkg::bus_rsp_t    bus_rsp;
   spi_bridge_pkg::spi_status_t status;

   // Bus master and SPI shifter
   spi_target u_target (
      .clk_i     (clk_i),
      .SSEL      (SSEL),
      .sck_i     (sck_i),
      .mosi_i    (mosi_i),
      .miso_o    (miso_o),
      .bus_req_o (bus_req),
      .bus_rsp_i (bus_rsp),
      .status_o  (status)
   );

   // Bus slave
   bus_byte_mem u_mem (
      .clk_i     (clk_i),
      .SSEL      (SSEL),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp)
   );

   // Status struct split onto pins
   assign overflow_o = status.overflow;
   assign underrun_o = status.underrun;

endmodule

`default_nettype wire

/* hdl/spi_target.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_consts.svh"

// SPI mode 0 target bridging onto the byte bus
// SCK and clk_i domains meet only through the two FIFOs and the SSEL/prefetch syncs
module spi_target (
   input  logic                        clk_i,
   input  logic                        SSEL,
   // SPI pins
   input  logic                        sck_i,
   input  logic                        mosi_i,
   output logic                        miso_o,
   // Bus master
   output spi_bridge_pkg::bus_req_t    bus_req_o,
   input  spi_bridge_pkg::bus_rsp_t    bus_rsp_i,
   // Sticky diagnostics
   output spi_bridge_pkg::spi_status_t status_o
);

   localparam logic [7:0] HEADER = `SPI_HEADER_BYTE;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ,
      ST_WAIT,
      ST_SEND
   } bus_state_t;

   // SPI domain
   logic [2:0] bit_cnt;
   logic [6:0] rx_sr;
   logic [6:0] tx_sr;
   logic [7:0] rx_byte;
   logic [7:0] tx_hold;
   logic       byte_end;
   logic       spi_req;
   logic       overflow_q;
   logic       underrun_q;

   // Bus domain
   logic       sel_meta;
   logic       sel_sync;
   logic       bus_rst;
   logic       req_flag;
   logic       req_sync;
   logic       req_sync_d;
   logic       fetch;
   bus_state_t state;
   logic       cyc_q;
   logic       stb_q;
   logic       we_q;
   logic [7:0] wdat_q;
   logic       tx_rst_q;

   // FIFO hookup
   logic       tx_push;
   logic       tx_pop;
   logic       tx_full;
   logic       tx_empty;
   logic [7:0] tx_head;
   logic       rx_push;
   logic       rx_pop;
   logic       rx_full;
   logic       rx_empty;
   logic [7:0] rx_head;

   //--------------------------------------------------------------------
   // SPI receive side, rising SCK
   //--------------------------------------------------------------------
   assign byte_end = (bit_cnt == 3'd7);
   // Last bit comes straight from the pin
   assign rx_byte  = {rx_sr, mosi_i};
   assign rx_push  = byte_end && !rx_full;
   // Next transmit byte leaves the TX FIFO on the byte boundary
   assign tx_pop   = byte_end && !tx_empty;

   always_ff @(posedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         bit_cnt    <= '0;
         spi_req    <= 1'b0;
         overflow_q <= 1'b0;
         underrun_q <= 1'b0;
      end else begin
         bit_cnt <= bit_cnt + 3'd1;
         // Prefetch request one SCK period wide
         spi_req <= (bit_cnt == 3'd1);
         if (byte_end && rx_full) begin
            overflow_q <= 1'b1;
         end
         if (byte_end && tx_empty) begin
            underrun_q <= 1'b1;
         end
      end
   end

   // MSB first shift in, and capture of the next byte to send
   always_ff @(posedge sck_i) begin
      rx_sr <= {rx_sr[5:0], mosi_i};
      if (byte_end) begin
         tx_hold <= tx_head;
      end
   end

   //--------------------------------------------------------------------
   // SPI transmit side, falling SCK
   //--------------------------------------------------------------------
   // Header bit 7 sits on MISO while deselected
   always_ff @(negedge sck_i or posedge SSEL) begin
      if (SSEL) begin
         miso_o <= HEADER[7];
         tx_sr  <= HEADER[6:0];
      end else if (bit_cnt == 3'd0) begin
         // Counter wrapped, start the prefetched byte
         miso_o <= tx_hold[7];
         tx_sr  <= tx_hold[6:0];
      end else begin
         miso_o <= tx_sr[6];
         tx_sr  <= {tx_sr[5:0], 1'b0};
      end
   end

   //--------------------------------------------------------------------
   // Crossing into clk_i
   //--------------------------------------------------------------------
   // Deselect takes effect at once, select is released on clk_i
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sel_meta <= 1'b0;
         sel_sync <= 1'b0;
      end else begin
         sel_meta <= 1'b1;
         sel_sync <= sel_meta;
      end
   end

   assign bus_rst = !sel_sync;

   // Flag set straight from the SCK domain, follows spi_req on clk_i
   always_ff @(posedge clk_i or posedge spi_req) begin
      if (spi_req) begin
         req_flag <= 1'b1;
      end else begin
         req_flag <= 1'b0;
      end
   end

   always_ff @(posedge clk_i or posedge bus_rst) begin
      if (bus_rst) begin
         req_sync   <= 1'b0;
         req_sync_d <= 1'b0;
      end else begin
         req_sync   <= req_flag;
         req_sync_d <= req_sync;
      end
   end

   // One fetch per byte, on the rising edge of the request
   assign fetch = req_sync && !req_sync_d;

   //--------------------------------------------------------------------
   // Bus master FSM
   //--------------------------------------------------------------------
   // Read data goes straight into the TX FIFO on ack
   assign tx_push = (state == ST_READ) && bus_rsp_i.ack && !tx_full;
   assign rx_pop  = (state == ST_WAIT) && !rx_empty;

   always_ff @(posedge clk_i or posedge bus_rst) begin
      if (bus_rst) begin
         state    <= ST_IDLE;
         cyc_q    <= 1'b0;
         stb_q    <= 1'b0;
         we_q     <= 1'b0;
         // TX FIFO held clear while deselected, stale prefetch gone
         tx_rst_q <= 1'b1;
      end else begin
         cyc_q    <= 1'b1;
         tx_rst_q <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (fetch) begin
                  stb_q <= 1'b1;
                  we_q  <= 1'b0;
                  state <= ST_READ;
               end
            end
            ST_READ: begin
               if (bus_rsp_i.ack) begin
                  stb_q <= 1'b0;
                  state <= ST_WAIT;
               end
            end
            // Wait for the byte being shifted in to land
            ST_WAIT: begin
               if (!rx_empty) begin
                  stb_q <= 1'b1;
                  we_q  <= 1'b1;
                  state <= ST_SEND;
               end
            end
            ST_SEND: begin
               if (bus_rsp_i.ack) begin
                  stb_q <= 1'b0;
                  we_q  <= 1'b0;
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Write data taken from the RX FIFO head
   always_ff @(posedge clk_i) begin
      if (rx_pop) begin
         wdat_q <= rx_head;
      end
   end

   assign bus_req_o = '{cyc: cyc_q, stb: stb_q, we: we_q, dat: wdat_q};
   assign status_o  = '{overflow: overflow_q, underrun: underrun_q};

   //--------------------------------------------------------------------
   // FIFOs
   //--------------------------------------------------------------------
   // Prefetched bytes, clk_i to SCK
   async_fifo #(
      .ADDR_W (`FIFO_ADDR_W)
   ) u_tx_fifo (
      .wr_clk_i  (clk_i),
      .wr_en_i   (tx_push),
      .wr_data_i (bus_rsp_i.dat),
      .wfull_o   (tx_full),
      .rd_clk_i  (sck_i),
      .rd_en_i   (tx_pop),
      .rd_data_o (tx_head),
      .rempty_o  (tx_empty),
      .rst_i     (tx_rst_q)
   );

   // Received bytes, SCK to clk_i
   async_fifo #(
      .ADDR_W (`FIFO_ADDR_W)
   ) u_rx_fifo (
      .wr_clk_i  (sck_i),
      .wr_en_i   (rx_push),
      .wr_data_i (rx_byte),
      .wfull_o   (rx_full),
      .rd_clk_i  (clk_i),
      .rd_en_i   (rx_pop),
      .rd_data_o (rx_head),
      .rempty_o  (rx_empty),
      .rst_i     (bus_rst)
   );

endmodule

`default_nettype wire

/* test/spi_master_bfm.svh */
`ifndef SPI_MASTER_BFM_SVH
`define SPI_MASTER_BFM_SVH

//----------------------------------------------------------------------
// SPI controller, mode 0, paced by the testbench clock
//----------------------------------------------------------------------

// Half an SCK period in clk_i cycles, 64 ns
localparam int SCK_HALF_CLKS = 8;

// Advance n rising clk_i edges, then settle 1 ns past the last one
task automatic step_clocks(input int n);
   repeat (n) @(posedge clk_i);
   #1;
endtask

// One whole frame
// Select, shift every MOSI byte MSB first, collect MISO, deselect
task automatic spi_frame(input byte_q_t tx_bytes, output byte_q_t rx_bytes);
   logic [7:0] rx_shift;
   rx_bytes = {};
   // SCK idles low, so no falling edge before the first bit
   ssel = 1'b0;
   foreach (tx_bytes[i]) begin
      rx_shift = '0;
      for (int b = 7; b >= 0; b--) begin
         // MOSI changes while SCK is low
         mosi = tx_bytes[i][b];
         // Low half, also the select setup time for the first bit
         step_clocks(SCK_HALF_CLKS);
         // MISO settled on the last falling edge
         rx_shift = {rx_shift[6:0], miso};
         sck = 1'b1;
         step_clocks(SCK_HALF_CLKS);
         sck = 1'b0;
      end
      rx_bytes.push_back(rx_shift);
   end
   // Last received byte still has to reach the memory
   step_clocks(SCK_HALF_CLKS);
   ssel = 1'b1;
   mosi = 1'b0;
   // Deselect gap between frames
   step_clocks(SCK_HALF_CLKS);
endtask

`endif

/* test/tb_spi_bridge.sv */
`timescale 1ns/1ns
`default_nettype none

`include "spi_bridge_consts.svh"

module tb_spi_bridge;

   localparam int CLK_HALF_NS   = 4;
   localparam int SCK_PERIOD_NS = 128;
   localparam int RESET_CLKS    = 10;
   localparam int MEM_DEPTH     = 2 ** `MEM_ADDR_W;
   localparam int RAND_FRAMES   = 20;

   typedef logic [7:0] byte_q_t[$];

   // DUT pins
   logic clk_i;
   logic ssel;
   logic sck;
   logic mosi;
   logic miso;
   logic ovf_flag;
   logic unf_flag;

   spi_bridge_pkg::spi_status_t status_now;
   // Flags seen at any clk_i edge since the test began
   spi_bridge_pkg::spi_status_t flags_seen;

   //--------------------------------------------------------------------
   // Scoreboard state
   //--------------------------------------------------------------------
   logic [7:0] mem_image [MEM_DEPTH];
   logic [7:0] exp_q [$];
   logic [7:0] got_q [$];
   int         idx_q [$];
   int         sent_cnt;
   int         done_cnt;
   int         pass_cnt;
   int         fail_cnt;
   int         status_errs;
   int         test_start_fails;
   integer     seed;
   int         rand_len [RAND_FRAMES];
   longint     watchdog_ns;
   logic       watchdog_armed;

   initial clk_i = 1'b0;
   always #CLK_HALF_NS clk_i = ~clk_i;

   spi_bridge_top uut (
      .clk_i      (clk_i),
      .SSEL       (ssel),
      .sck_i      (sck),
      .mosi_i     (mosi),
      .miso_o     (miso),
      .overflow_o (ovf_flag),
      .underrun_o (unf_flag)
   );

   assign status_now = '{overflow: ovf_flag, underrun: unf_flag};

   `include "spi_master_bfm.svh"

   // Flags clear on deselect, so they are caught while still selected
   always @(posedge clk_i) begin
      if (ovf_flag !== 1'b0) begin
         flags_seen.overflow = 1'b1;
      end
      if (unf_flag !== 1'b0) begin
         flags_seen.underrun = 1'b1;
      end
   end

   //--------------------------------------------------------------------
   // Reference model and checks
   //--------------------------------------------------------------------
   // Header, then the old image from address 0; the last prefetch is never sent
   function automatic void ref_frame(input byte_q_t mosi_bytes, output byte_q_t miso_bytes);
      int n;
      n = mosi_bytes.size();
      miso_bytes = {};
      miso_bytes.push_back(`SPI_HEADER_BYTE);
      for (int i = 0; i < n - 1; i++) begin
         miso_bytes.push_back(mem_image[i % MEM_DEPTH]);
      end
      // Write pointer also restarts at 0
      for (int i = 0; i < n; i++) begin
         mem_image[i % MEM_DEPTH] = mosi_bytes[i];
      end
   endfunction

   task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
      if (got !== exp) begin
         fail_cnt++;
         $display("MISMATCH at %0t ns: MISO byte %0d expected %02h, got %02h",
                  $time, idx, exp, got);
      end else begin
         pass_cnt++;
      end
   endtask

   task automatic check_status(input spi_bridge_pkg::spi_status_t got,
                               input spi_bridge_pkg::spi_status_t exp,
                               input string what);
      if (got !== exp) begin
         fail_cnt++;
         status_errs++;
         $display("MISMATCH at %0t ns: status %s expected ovf=%0b unf=%0b, got ovf=%0b unf=%0b",
                  $time, what, exp.overflow, exp.underrun, got.overflow, got.underrun);
      end else begin
         pass_cnt++;
      end
   endtask

   // Compare process, fed by run_frame
   initial begin : compare_proc
      logic [7:0] exp_b;
      logic [7:0] got_b;
      int         idx;
      forever begin
         wait (got_q.size() > 0);
         exp_b = exp_q.pop_front();
         got_b = got_q.pop_front();
         idx   = idx_q.pop_front();
         // Image bytes never written since power-up
         if (!$isunknown(exp_b)) begin
            check_byte(got_b, exp_b, idx);
         end
         done_cnt++;
      end
   end

   // Predict, shift, hand both to the compare process and wait for it
   task automatic run_frame(input byte_q_t mosi_bytes);
      byte_q_t exp_bytes;
      byte_q_t got_bytes;
      ref_frame(mosi_bytes, exp_bytes);
      spi_frame(mosi_bytes, got_bytes);
      for (int i = 0; i < exp_bytes.size(); i++) begin
         exp_q.push_back(exp_bytes[i]);
         got_q.push_back(got_bytes[i]);
         idx_q.push_back(i);
         sent_cnt++;
      end
      wait (done_cnt == sent_cnt);
   endtask

   task automatic begin_test();
      test_start_fails = fail_cnt;
      flags_seen       = '0;
   endtask

   task automatic end_test(input int num, input string name);
      check_status(flags_seen, '0, name);
      if (fail_cnt == test_start_fails) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, fail_cnt - test_start_fails);
      end
   endtask

   //--------------------------------------------------------------------
   // Test sequence
   //--------------------------------------------------------------------
   initial begin : main_seq
      byte_q_t frame_a;
      byte_q_t frame_b;
      byte_q_t frame_c;
      byte_q_t frame_r;
      longint  sck_periods;
      ssel       = 1'b0;
      sck        = 1'b0;
      mosi       = 1'b0;
      seed       = 32'h2ca6;
      flags_seen = '0;
      foreach (mem_image[a]) begin
         mem_image[a] = 'x;
      end
      // Random lengths drawn first so the whole run is known up front
      sck_periods = 3 * (16 * 8 + 4) + (5 * 8 + 4);
      for (int f = 0; f < RAND_FRAMES; f++) begin
         rand_len[f] = 2 + ($unsigned($random(seed)) % 15);
         sck_periods += rand_len[f] * 8 + 4;
      end
      watchdog_ns    = 2 * (sck_periods * SCK_PERIOD_NS + RESET_CLKS * 2 * CLK_HALF_NS);
      watchdog_armed = 1'b1;

      // Rising SSEL just after time 0 clears the SCK-domain flops
      #1;
      ssel = 1'b1;

      repeat (RESET_CLKS) @(posedge clk_i);
      #1;
      check_status(status_now, '0, "after reset");

      // Header on a fresh memory
      begin_test();
      for (int i = 0; i < 16; i++) begin
         frame_a.push_back(8'(8'h31 + i * 8'h1d));
      end
      run_frame(frame_a);
      end_test(1, "header");

      // Previous frame comes back shifted by the header
      begin_test();
      for (int i = 0; i < 16; i++) begin
         frame_b.push_back(8'(8'hc4 - i * 8'h0b));
      end
      run_frame(frame_b);
      end_test(2, "readback");

      // Short frame merges into the old image
      begin_test();
      for (int i = 0; i < 5; i++) begin
         frame_c.push_back(8'(8'he0 + i));
      end
      run_frame(frame_c);
      run_frame(frame_a);
      end_test(3, "partial overwrite");

      begin_test();
      for (int f = 0; f < RAND_FRAMES; f++) begin
         frame_r = {};
         for (int i = 0; i < rand_len[f]; i++) begin
            frame_r.push_back(8'($random(seed)));
         end
         run_frame(frame_r);
      end
      end_test(4, "random lengths");

      if (status_errs == 0) begin
         $display("test 5 diagnostics: ok");
      end else begin
         $display("test 5 diagnostics: %0d errors", status_errs);
      end

      $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

   // Twice the nominal run length
   initial begin : watchdog
      wait (watchdog_armed === 1'b1);
      #(watchdog_ns);
      $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
      $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire
